// ==== build.f ====
src/cache_pkg.sv
src/cache_l1_controller.sv
src/cache_l1_datapath.sv
src/mem_arbiter.sv
src/main_mem.sv
src/dual_cache_top.sv
tests/tb_dual_cache.sv

// ==== tests/tb_dual_cache.sv ====
// testbench for the dual l1 cache: clock, reset, cpu driver, shadow model, checks, scenarios
`timescale 1ns/1ps

module tb_dual_cache;

    import cache_pkg::*;

    logic  clk = 1'b0;
    logic  rst;
    logic  cpu0_cyc;
    logic  cpu0_stb;
    logic  cpu0_we;
    addr_t cpu0_adr;
    word_t cpu0_dat_w;
    word_t cpu0_dat_r;
    logic  cpu0_ack;
    logic  cpu0_rty;
    logic  cpu1_cyc;
    logic  cpu1_stb;
    logic  cpu1_we;
    addr_t cpu1_adr;
    word_t cpu1_dat_w;
    word_t cpu1_dat_r;
    logic  cpu1_ack;
    logic  cpu1_rty;

    int data_errors;
    int status_errors;
    int latency_errors;
    int timeouts;

    // expected memory image, one word per address
    word_t       shadow [mem_words];
    logic [31:0] rng_state [2];

    dual_cache_top #(.sets(16), .depth(mem_words)) u_dual_cache_top (
        .clk(clk), .rst(rst),
        .cpu0_cyc(cpu0_cyc), .cpu0_stb(cpu0_stb), .cpu0_we(cpu0_we),
        .cpu0_adr(cpu0_adr), .cpu0_dat_w(cpu0_dat_w), .cpu0_dat_r(cpu0_dat_r),
        .cpu0_ack(cpu0_ack), .cpu0_rty(cpu0_rty),
        .cpu1_cyc(cpu1_cyc), .cpu1_stb(cpu1_stb), .cpu1_we(cpu1_we),
        .cpu1_adr(cpu1_adr), .cpu1_dat_w(cpu1_dat_w), .cpu1_dat_r(cpu1_dat_r),
        .cpu1_ack(cpu1_ack), .cpu1_rty(cpu1_rty)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // power-up rule: inverted address on top, address below
    function automatic word_t power_up_word(input addr_t adr);
        return {16'hffff ^ adr, adr};
    endfunction

    function automatic word_t expected_word(input addr_t adr);
        return shadow[adr];
    endfunction

    task automatic check_data(input int port, input addr_t adr, input word_t got,
                              input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t port %0d read of %h returned %h, expected %h",
                     $time, port, adr, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_status(input int port, input logic in_reset, input logic ack,
                                input logic rty);
        if (ack === 1'b1 && rty === 1'b1) begin
            $display("[FAIL] %0t port %0d shows ack and rty together", $time, port);
            status_errors++;
        end
        if (ack !== 1'b1 && rty !== 1'b1) begin
            $display("[FAIL] %0t port %0d shows neither ack nor rty", $time, port);
            status_errors++;
        end
        if (in_reset && ack !== 1'b0) begin
            $display("[FAIL] %0t port %0d ack is %b during reset", $time, port, ack);
            status_errors++;
        end
    endtask

    task automatic check_latency(input int port, input addr_t adr, input int got,
                                 input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t port %0d access to %h waited %0d cycles, expected %0d",
                     $time, port, adr, got, exp);
            latency_errors++;
        end
    endtask

    task automatic drive_port(input int port, input logic req, input logic we,
                              input addr_t adr, input word_t data);
        if (port == 0) begin
            cpu0_cyc = req;
            cpu0_stb = req;
            cpu0_we = we;
            cpu0_adr = adr;
            cpu0_dat_w = data;
        end else begin
            cpu1_cyc = req;
            cpu1_stb = req;
            cpu1_we = we;
            cpu1_adr = adr;
            cpu1_dat_w = data;
        end
    endtask

    // one request, held through retries until ack
    task automatic cpu_access(input int port, input logic we, input addr_t adr,
                              input word_t data, output int waited);
        logic  ack;
        word_t rdata;
        bit    done;
        waited = 0;
        done = 1'b0;
        @(posedge clk);
        #2;
        drive_port(port, 1'b1, we, adr, data);
        while (!done && waited < 200) begin
            @(negedge clk);
            ack = (port == 0) ? cpu0_ack : cpu1_ack;
            rdata = (port == 0) ? cpu0_dat_r : cpu1_dat_r;
            if (ack === 1'b1) begin
                done = 1'b1;
                if (we) begin
                    shadow[adr] = data;
                end else begin
                    check_data(port, adr, rdata, expected_word(adr));
                end
            end else begin
                waited++;
            end
        end
        if (!done) begin
            $display("Port %0d got no ack within 200 cycles for address %h.", port, adr);
            timeouts++;
        end
        // write lands on this edge, then the request drops
        @(posedge clk);
        #2;
        drive_port(port, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic cold_read_test();
        int    waited;
        addr_t adr;
        for (int p = 0; p < 2; p++) begin
            adr = (p == 0) ? 16'h0123 : 16'h8123;
            cpu_access(p, 1'b0, adr, '0, waited);
            // second read must hit with no retry
            cpu_access(p, 1'b0, adr, '0, waited);
            check_latency(p, adr, waited, 0);
        end
    endtask

    task automatic write_read_test();
        int    waited;
        addr_t adr;
        for (int p = 0; p < 2; p++) begin
            adr = (p == 0) ? 16'h0200 : 16'h8200;
            cpu_access(p, 1'b1, adr, 32'hdead_beef ^ word_t'(p), waited);
            cpu_access(p, 1'b0, adr, '0, waited);
        end
    endtask

    // three tags in set 5 against two ways
    task automatic eviction_test();
        int    waited;
        addr_t adr;
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 3; k++) begin
                adr = ((p == 0) ? 16'h0000 : 16'h8000) + 16'h0305 + addr_t'(k) * 16'h0110;
                cpu_access(p, 1'b1, adr, 32'h1000_0000 * (k + 1) + adr, waited);
            end
            for (int k = 0; k < 3; k++) begin
                adr = ((p == 0) ? 16'h0000 : 16'h8000) + 16'h0305 + addr_t'(k) * 16'h0110;
                cpu_access(p, 1'b0, adr, '0, waited);
            end
        end
    endtask

    task automatic parallel_miss_test();
        int w0;
        int w1;
        fork
            cpu_access(0, 1'b0, 16'h0777, '0, w0);
            cpu_access(1, 1'b0, 16'h8777, '0, w1);
        join
    endtask

    // small window per port so hits, misses and evictions all occur
    task automatic random_traffic(input int port, input int count);
        logic [31:0] r;
        addr_t       adr;
        int          waited;
        for (int k = 0; k < count; k++) begin
            rng_state[port] = xorshift(rng_state[port]);
            r = rng_state[port];
            adr = {port[0], 8'h00, r[6:0]};
            rng_state[port] = xorshift(rng_state[port]);
            cpu_access(port, r[16], adr, rng_state[port], waited);
        end
    endtask

    always @(negedge clk) begin
        check_status(0, rst, cpu0_ack, cpu0_rty);
        check_status(1, rst, cpu1_ack, cpu1_rty);
    end

    initial begin
        int total;
        data_errors = 0;
        status_errors = 0;
        latency_errors = 0;
        timeouts = 0;
        rst = 1'b1;
        // requests pending through reset must not be acked
        drive_port(0, 1'b1, 1'b0, 16'h0040, '0);
        drive_port(1, 1'b1, 1'b0, 16'h8040, '0);
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = power_up_word(addr_t'(i));
        end
        rng_state[0] = 32'h3874_2675;
        rng_state[1] = xorshift(32'h3874_2675);
        repeat (10) @(posedge clk);
        #2;
        drive_port(0, 1'b0, 1'b0, '0, '0);
        drive_port(1, 1'b0, 1'b0, '0, '0);
        rst = 1'b0;
        cold_read_test();
        write_read_test();
        eviction_test();
        parallel_miss_test();
        fork
            random_traffic(0, 300);
            random_traffic(1, 300);
        join
        repeat (2) @(posedge clk);
        total = data_errors + status_errors + latency_errors + timeouts;
        $display("errors: data %0d, status %0d, latency %0d, timeouts %0d",
                 data_errors, status_errors, latency_errors, timeouts);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== src/dual_cache_top.sv ====
// two l1 caches sharing one backing memory through a round-robin arbiter
`timescale 1ns/1ps

module dual_cache_top #(
    parameter int sets = 16,
    parameter int depth = cache_pkg::mem_words
) (
    input  logic             clk,
    input  logic             rst,
    // cpu port 0
    input  logic             cpu0_cyc,
    input  logic             cpu0_stb,
    input  logic             cpu0_we,
    input  cache_pkg::addr_t cpu0_adr,
    input  cache_pkg::word_t cpu0_dat_w,
    output cache_pkg::word_t cpu0_dat_r,
    output logic             cpu0_ack,
    output logic             cpu0_rty,
    // cpu port 1
    input  logic             cpu1_cyc,
    input  logic             cpu1_stb,
    input  logic             cpu1_we,
    input  cache_pkg::addr_t cpu1_adr,
    input  cache_pkg::word_t cpu1_dat_w,
    output cache_pkg::word_t cpu1_dat_r,
    output logic             cpu1_ack,
    output logic             cpu1_rty
);

    import cache_pkg::*;

    // controller to datapath, cache 0 and 1
    logic c0_hit_0, c0_hit_1, c0_dirty, c0_lru;
    logic c0_way_sel, c0_src_sel, c0_bypass_sel, c0_load, c0_load_lru;
    logic c1_hit_0, c1_hit_1, c1_dirty, c1_lru;
    logic c1_way_sel, c1_src_sel, c1_bypass_sel, c1_load, c1_load_lru;

    // cache to arbiter
    logic  m0_cyc, m0_stb, m0_we, m0_ack, m0_rty;
    addr_t m0_adr;
    word_t m0_dat_w, m0_dat_r;
    logic  m1_cyc, m1_stb, m1_we, m1_ack, m1_rty;
    addr_t m1_adr;
    word_t m1_dat_w, m1_dat_r;

    // arbiter to memory
    logic  mem_cyc, mem_stb, mem_we, mem_ack;
    addr_t mem_adr;
    word_t mem_dat_w, mem_dat_r;

    cache_l1_controller u_ctrl_0 (
        .clk(clk), .rst(rst),
        .hit_0(c0_hit_0), .hit_1(c0_hit_1), .dirty(c0_dirty), .lru(c0_lru),
        .in_cyc(cpu0_cyc), .in_stb(cpu0_stb), .in_we(cpu0_we),
        .out_ack(m0_ack), .out_rty(m0_rty),
        .cache_way_sel(c0_way_sel), .data_source_sel(c0_src_sel),
        .tag_bypass_sel(c0_bypass_sel), .load(c0_load), .load_lru(c0_load_lru),
        .in_ack(cpu0_ack), .in_rty(cpu0_rty),
        .out_cyc(m0_cyc), .out_stb(m0_stb), .out_we(m0_we)
    );

    cache_l1_datapath #(.sets(sets)) u_dp_0 (
        .clk(clk), .rst(rst),
        .cpu_adr(cpu0_adr), .cpu_dat_w(cpu0_dat_w), .mem_dat_r(m0_dat_r),
        .cache_way_sel(c0_way_sel), .data_source_sel(c0_src_sel),
        .tag_bypass_sel(c0_bypass_sel), .load(c0_load), .load_lru(c0_load_lru),
        .hit_0(c0_hit_0), .hit_1(c0_hit_1), .dirty(c0_dirty), .lru(c0_lru),
        .cpu_dat_r(cpu0_dat_r), .mem_adr(m0_adr), .mem_dat_w(m0_dat_w)
    );

    cache_l1_controller u_ctrl_1 (
        .clk(clk), .rst(rst),
        .hit_0(c1_hit_0), .hit_1(c1_hit_1), .dirty(c1_dirty), .lru(c1_lru),
        .in_cyc(cpu1_cyc), .in_stb(cpu1_stb), .in_we(cpu1_we),
        .out_ack(m1_ack), .out_rty(m1_rty),
        .cache_way_sel(c1_way_sel), .data_source_sel(c1_src_sel),
        .tag_bypass_sel(c1_bypass_sel), .load(c1_load), .load_lru(c1_load_lru),
        .in_ack(cpu1_ack), .in_rty(cpu1_rty),
        .out_cyc(m1_cyc), .out_stb(m1_stb), .out_we(m1_we)
    );

    cache_l1_datapath #(.sets(sets)) u_dp_1 (
        .clk(clk), .rst(rst),
        .cpu_adr(cpu1_adr), .cpu_dat_w(cpu1_dat_w), .mem_dat_r(m1_dat_r),
        .cache_way_sel(c1_way_sel), .data_source_sel(c1_src_sel),
        .tag_bypass_sel(c1_bypass_sel), .load(c1_load), .load_lru(c1_load_lru),
        .hit_0(c1_hit_0), .hit_1(c1_hit_1), .dirty(c1_dirty), .lru(c1_lru),
        .cpu_dat_r(cpu1_dat_r), .mem_adr(m1_adr), .mem_dat_w(m1_dat_w)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we),
        .m0_adr(m0_adr), .m0_dat_w(m0_dat_w),
        .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we),
        .m1_adr(m1_adr), .m1_dat_w(m1_dat_w),
        .m0_ack(m0_ack), .m0_rty(m0_rty), .m0_dat_r(m0_dat_r),
        .m1_ack(m1_ack), .m1_rty(m1_rty), .m1_dat_r(m1_dat_r),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
        .mem_adr(mem_adr), .mem_dat_w(mem_dat_w),
        .mem_ack(mem_ack), .mem_dat_r(mem_dat_r)
    );

    main_mem #(.depth(depth)) u_main_mem (
        .clk(clk), .rst(rst),
        .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
        .adr(mem_adr), .dat_w(mem_dat_w),
        .ack(mem_ack), .dat_r(mem_dat_r)
    );

endmodule

// ==== src/main_mem.sv ====
// backing word memory with registered four-phase ack and address power-up pattern
`timescale 1ns/1ps

module main_mem #(
    parameter int depth = cache_pkg::mem_words
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  cache_pkg::addr_t adr,
    input  cache_pkg::word_t dat_w,
    output logic             ack,
    output cache_pkg::word_t dat_r
);

    import cache_pkg::*;

    word_t mem [depth];

    // high half is the inverted address, low half the address
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = {~addr_t'(i), addr_t'(i)};
        end
    end

    // ack follows stb by one cycle on both edges
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc & stb;
        end
    end

    always @(posedge clk) begin
        if (cyc && stb && ack && we) begin
            mem[adr] <= dat_w;
        end
    end

    assign dat_r = mem[adr];

endmodule

// ==== src/mem_arbiter.sv ====
// round-robin arbiter sharing one memory port between two cache masters
`timescale 1ns/1ps

module mem_arbiter (
    input  logic             clk,
    input  logic             rst,
    // master 0
    input  logic             m0_cyc,
    input  logic             m0_stb,
    input  logic             m0_we,
    input  cache_pkg::addr_t m0_adr,
    input  cache_pkg::word_t m0_dat_w,
    // master 1
    input  logic             m1_cyc,
    input  logic             m1_stb,
    input  logic             m1_we,
    input  cache_pkg::addr_t m1_adr,
    input  cache_pkg::word_t m1_dat_w,
    // responses
    output logic             m0_ack,
    output logic             m0_rty,
    output cache_pkg::word_t m0_dat_r,
    output logic             m1_ack,
    output logic             m1_rty,
    output cache_pkg::word_t m1_dat_r,
    // memory side
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output cache_pkg::addr_t mem_adr,
    output cache_pkg::word_t mem_dat_w,
    input  logic             mem_ack,
    input  cache_pkg::word_t mem_dat_r
);

    // owner of the memory port, 0 or 1
    logic grant;
    logic grant_cyc;
    logic other_cyc;

    assign grant_cyc = grant ? m1_cyc : m0_cyc;
    assign other_cyc = grant ? m0_cyc : m1_cyc;

    // hand over only once the owner has let go
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= 1'b0;
        end else if (!grant_cyc && other_cyc) begin
            grant <= ~grant;
        end
    end

    assign mem_cyc = grant_cyc;
    assign mem_stb = grant ? m1_stb : m0_stb;
    assign mem_we = grant ? m1_we : m0_we;
    assign mem_adr = grant ? m1_adr : m0_adr;
    assign mem_dat_w = grant ? m1_dat_w : m0_dat_w;

    // the waiting master sees retry
    assign m0_rty = grant;
    assign m1_rty = ~grant;
    assign m0_ack = mem_ack & ~grant;
    assign m1_ack = mem_ack & grant;
    assign m0_dat_r = mem_dat_r;
    assign m1_dat_r = mem_dat_r;

    // masters only strobe inside their own bus cycle
    a_stb_owner: assert property (@(posedge clk) disable iff (rst)
        mem_stb |-> (grant ? m1_cyc : m0_cyc));

    // ownership never moves under an outstanding ack
    a_grant_hold: assert property (@(posedge clk) disable iff (rst) mem_ack |=> $stable(grant));

endmodule

// ==== src/cache_l1_datapath.sv ====
// two-way tag, data, valid, dirty and lru storage with hit compare and bus muxing
`timescale 1ns/1ps

module cache_l1_datapath #(
    parameter int sets = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::addr_t  cpu_adr,
    input  cache_pkg::word_t  cpu_dat_w,
    input  cache_pkg::word_t  mem_dat_r,
    input  logic              cache_way_sel,
    input  logic              data_source_sel,
    input  logic              tag_bypass_sel,
    input  logic              load,
    input  logic              load_lru,
    output logic              hit_0,
    output logic              hit_1,
    output logic              dirty,
    output logic              lru,
    output cache_pkg::word_t  cpu_dat_r,
    output cache_pkg::addr_t  mem_adr,
    output cache_pkg::word_t  mem_dat_w
);

    import cache_pkg::*;

    // per way line storage
    tag_t  tag_arr   [2][sets];
    word_t data_arr  [2][sets];
    logic  valid_arr [2][sets];
    logic  dirty_arr [2][sets];
    // way to replace next, per set
    logic  lru_arr   [sets];

    index_t idx;
    tag_t   cpu_tag;
    word_t  fill_word;

    assign idx = cpu_adr[index_w-1:0];
    assign cpu_tag = cpu_adr[addr_w-1:index_w];

    assign hit_0 = valid_arr[0][idx] && (tag_arr[0][idx] == cpu_tag);
    assign hit_1 = valid_arr[1][idx] && (tag_arr[1][idx] == cpu_tag);

    // victim status always refers to the lru way
    assign lru = lru_arr[idx];
    assign dirty = valid_arr[lru][idx] && dirty_arr[lru][idx];

    assign cpu_dat_r = data_arr[cache_way_sel][idx];
    assign mem_dat_w = data_arr[cache_way_sel][idx];

    // flush uses the stored tag, fetch the cpu address
    assign mem_adr = tag_bypass_sel ? cpu_adr : {tag_arr[cache_way_sel][idx], idx};

    assign fill_word = data_source_sel ? mem_dat_r : cpu_dat_w;

    always_ff @(posedge clk) begin
        if (load) begin
            tag_arr[cache_way_sel][idx] <= cpu_tag;
            data_arr[cache_way_sel][idx] <= fill_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                valid_arr[0][s] <= 1'b0;
                valid_arr[1][s] <= 1'b0;
                dirty_arr[0][s] <= 1'b0;
                dirty_arr[1][s] <= 1'b0;
                lru_arr[s] <= 1'b0;
            end
        end else begin
            if (load) begin
                valid_arr[cache_way_sel][idx] <= 1'b1;
                // refilled lines are clean, cpu writes make them dirty
                dirty_arr[cache_way_sel][idx] <= ~data_source_sel;
            end
            if (load_lru) begin
                lru_arr[idx] <= ~cache_way_sel;
            end
        end
    end

    // a refill only follows a miss, so a tag never sits in both ways
    a_one_way_hit: assert property (@(posedge clk) disable iff (rst) !(hit_0 && hit_1));

endmodule

// ==== src/cache_l1_controller.sv ====
// hit/miss FSM steering one l1 datapath, its cpu port and its memory port
`timescale 1ns/1ps

module cache_l1_controller (
    input  logic clk,
    input  logic rst,
    // status from the datapath
    input  logic hit_0,
    input  logic hit_1,
    input  logic dirty,
    input  logic lru,
    // cpu side request
    input  logic in_cyc,
    input  logic in_stb,
    input  logic in_we,
    // downstream response
    input  logic out_ack,
    input  logic out_rty,
    // datapath selects
    output logic cache_way_sel,
    output logic data_source_sel,
    output logic tag_bypass_sel,
    output logic load,
    output logic load_lru,
    // cpu side response
    output logic in_ack,
    output logic in_rty,
    // downstream request
    output logic out_cyc,
    output logic out_stb,
    output logic out_we
);

    typedef enum logic [2:0] {
        idle_hit,
        flush,
        flush_2,
        fetch,
        fetch_2
    } state_t;

    state_t state;
    state_t next_state;

    logic request;
    logic hit;

    assign request = in_cyc & in_stb;
    assign hit = hit_0 | hit_1;

    always_comb begin
        cache_way_sel = 1'b0;
        data_source_sel = 1'b0;
        tag_bypass_sel = 1'b0;
        load = 1'b0;
        load_lru = 1'b0;
        // cpu is told to retry unless a hit is served
        in_ack = 1'b0;
        in_rty = 1'b1;
        out_cyc = 1'b0;
        out_stb = 1'b0;
        out_we = 1'b0;
        case (state)
            idle_hit: begin
                if (request && hit) begin
                    cache_way_sel = hit_1;
                    load_lru = 1'b1;
                    // cpu data goes in only on a write hit
                    load = in_we;
                    in_ack = 1'b1;
                    in_rty = 1'b0;
                end else if (request) begin
                    // ask the arbiter for the bus
                    out_cyc = 1'b1;
                end
            end
            flush: begin
                // write back the dirty lru line at its stored tag
                cache_way_sel = lru;
                out_cyc = 1'b1;
                out_stb = 1'b1;
                out_we = 1'b1;
            end
            flush_2: begin
                out_cyc = 1'b1;
                out_we = 1'b1;
            end
            fetch: begin
                // refill the lru way from memory at the cpu address
                cache_way_sel = lru;
                tag_bypass_sel = 1'b1;
                data_source_sel = 1'b1;
                load = 1'b1;
                out_cyc = 1'b1;
                out_stb = 1'b1;
            end
            fetch_2: begin
                out_cyc = 1'b1;
            end
            default: begin
                out_cyc = 1'b0;
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            idle_hit: begin
                // leave only once the arbiter has granted us
                if (request && !hit && !out_rty) begin
                    next_state = dirty ? flush : fetch;
                end
            end
            flush: begin
                if (out_ack) begin
                    next_state = flush_2;
                end
            end
            flush_2: begin
                if (!out_ack) begin
                    next_state = fetch;
                end
            end
            fetch: begin
                if (out_ack) begin
                    next_state = fetch_2;
                end
            end
            fetch_2: begin
                if (!out_ack) begin
                    next_state = idle_hit;
                end
            end
            default: begin
                next_state = idle_hit;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle_hit;
        end else begin
            state <= next_state;
        end
    end

    // downstream ack only arrives inside our own bus cycle
    a_ack_in_cyc: assert property (@(posedge clk) disable iff (rst) out_ack |-> out_cyc);

    // a new strobe starts only after the previous ack has fallen
    a_stb_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(out_stb) |-> !out_ack);

endmodule

// ==== src/cache_pkg.sv ====
// shared widths and word, address, tag and index types for the cache subsystem
package cache_pkg;

    // word address and data widths
    localparam int addr_w = 16;
    localparam int word_w = 32;

    // 16 sets, the rest of the address is tag
    localparam int index_w = 4;
    localparam int tag_w = addr_w - index_w;

    // backing store covers the whole word address space
    localparam int mem_words = 2 ** addr_w;

    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [word_w-1:0]  word_t;
    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] index_t;

endpackage
